// ==== source/dstream_pkg.sv ====
package dstream_pkg;

   localparam int DATA_W    = 64;   // beat width of the desc/data interface
   localparam int BE_W      = 8;    // one enable per byte
   localparam int LEN_W     = 10;   // tlp length field, in dw
   localparam int DW_ADDR_W = 30;   // dw address, taken from the low 32 address bits

   // fmt[1] set for write, fmt[0] set for 4dw header
   localparam logic [4:0] TLP_TYPE_MEM  = 5'b00000;
   localparam logic [6:0] CPLD_FMT_TYPE = 7'h4A;    // completion with data

   ////////////////////////////////////////
   // rx descriptor, 136 bits
   ////////////////////////////////////////

   typedef struct packed {
      logic [7:0]       bar_hit;    // [135:128]
      logic             rsvd;
      logic [1:0]       fmt;        // [126:125]
      logic [4:0]       tlp_type;   // [124:120]
      logic [13:0]      misc;       // tc, td, ep, attr
      logic [LEN_W-1:0] length;     // [105:96]
      logic [15:0]      req_id;
      logic [7:0]       tag;
      logic [7:0]       be;         // last and first dw enables
      logic [31:0]      addr;       // [63:32]
      logic [31:0]      unused;
   } rx_desc_hdr3_t;

   typedef struct packed {
      logic [7:0]       bar_hit;
      logic             rsvd;
      logic [1:0]       fmt;
      logic [4:0]       tlp_type;
      logic [13:0]      misc;
      logic [LEN_W-1:0] length;
      logic [15:0]      req_id;
      logic [7:0]       tag;
      logic [7:0]       be;
      logic [63:0]      addr;       // full 64-bit address in [63:0]
   } rx_desc_hdr4_t;

   // fmt[0] picks which view holds the address
   typedef union packed {
      rx_desc_hdr3_t h3;
      rx_desc_hdr4_t h4;
   } rx_desc_u;

endpackage

// ==== source/cpl_job_if.sv ====
`timescale 1ns/1ps

interface cpl_job_if;

   logic                              start;       // one cycle pulse per read
   logic [dstream_pkg::DW_ADDR_W-1:0] addr_dw;     // first dw of the read
   logic [dstream_pkg::LEN_W-1:0]     num_beats;   // 64-bit words to fetch
   logic [dstream_pkg::LEN_W-1:0]     length;      // requested dw
   logic [7:0]                        tag;
   logic [15:0]                       req_id;
   logic [6:0]                        lower_addr;
   logic                              done;        // last cpl beat accepted

   modport src (output start, addr_dw, num_beats, length, tag, req_id, lower_addr,
                input  done);
   modport rd  (input start, addr_dw, num_beats);
   modport tx  (input start, num_beats, length, tag, req_id, lower_addr, output done);

endinterface

// ==== source/beat_fifo_if.sv ====
`timescale 1ns/1ps

interface beat_fifo_if;

   logic                           wr;
   logic [dstream_pkg::DATA_W-1:0] wdata;
   logic                           rd;
   logic [dstream_pkg::DATA_W-1:0] rdata;        // valid the cycle after rd
   logic                           empty;
   logic                           almost_full;  // leaves room for reads in flight

   modport push  (output wr, wdata, input almost_full);
   modport pop   (output rd, input rdata, empty);
   modport store (input wr, wdata, rd, output rdata, empty, almost_full);

endinterface

// ==== source/rx_req_ctrl.sv ====
`timescale 1ns/1ps

module rx_req_ctrl (
   input  logic                  clk_in,
   input  logic                  rstn,
   input  logic                  rx_req,
   input  dstream_pkg::rx_desc_u rx_desc,
   input  logic                  rx_dfr,
   output logic                  rx_ack,
   output logic                  wr_active,
   cpl_job_if.src                job
);

   localparam logic [1:0] RX_IDLE     = 2'd0;  // wait for rx_req
   localparam logic [1:0] RX_ACK      = 2'd1;  // rx_ack is high
   localparam logic [1:0] RX_WR_PAYLD = 2'd2;  // write beats go to memory
   localparam logic [1:0] RX_WAIT_CPL = 2'd3;  // read job owned by the tx side

   logic [1:0]                  state;
   logic                        is_wr;      // latched fmt[1]
   logic                        is_mem;
   logic [31:0]                 addr_sel;   // byte address, either header size
   logic [dstream_pkg::LEN_W:0] dw_span;

   assign is_mem   = rx_desc.h3.tlp_type == dstream_pkg::TLP_TYPE_MEM;
   assign addr_sel = rx_desc.h3.fmt[0] ? rx_desc.h4.addr[31:0] : rx_desc.h3.addr;

   // dw offset in the first word plus length, plus one to round up
   assign dw_span   = {1'b0, rx_desc.h3.length} + addr_sel[2] + 1'b1;
   assign wr_active = is_wr & ((state == RX_ACK) | (state == RX_WR_PAYLD));

   ////////////////////////////////////////
   // request FSM
   ////////////////////////////////////////

   always_ff @(posedge clk_in or negedge rstn) begin
      if (!rstn) begin
         state     <= RX_IDLE;
         rx_ack    <= 1'b0;
         is_wr     <= 1'b0;
         job.start <= 1'b0;
      end else begin
         rx_ack    <= 1'b0;   // both are pulses
         job.start <= 1'b0;
         case (state)
            RX_IDLE: begin
               if (rx_req && is_mem) begin
                  state  <= RX_ACK;
                  rx_ack <= 1'b1;
                  is_wr  <= rx_desc.h3.fmt[1];
               end
            end
            RX_ACK: begin
               if (!is_wr) begin
                  job.start <= 1'b1;   // two cycles after rx_req
                  state     <= RX_WAIT_CPL;
               end else begin
                  state <= rx_dfr ? RX_WR_PAYLD : RX_IDLE;
               end
            end
            RX_WR_PAYLD: if (!rx_dfr) state <= RX_IDLE;    // last beat seen
            default:     if (job.done) state <= RX_IDLE;
         endcase
      end
   end

   // header fields held for the cpl, stable until done
   always_ff @(posedge clk_in) begin
      if (state == RX_IDLE && rx_req && is_mem) begin
         job.length     <= rx_desc.h3.length;
         job.tag        <= rx_desc.h3.tag;
         job.req_id     <= rx_desc.h3.req_id;
         job.lower_addr <= addr_sel[6:0];
         job.addr_dw    <= addr_sel[31:2];
         job.num_beats  <= dw_span[dstream_pkg::LEN_W:1];
      end
   end

   a_ack_single : assert property (@(posedge clk_in) disable iff (!rstn)
      rx_ack |=> !rx_ack)
      else $error("rx_ack held for two cycles");

endmodule

// ==== source/mem_wr_path.sv ====
`timescale 1ns/1ps

module mem_wr_path #(
   parameter int MEM_ADDR_WIDTH = 10
) (
   input  logic                             clk_in,
   input  logic                             rstn,
   input  dstream_pkg::rx_desc_u            rx_desc,
   input  logic                             wr_active,
   input  logic                             rx_dv,
   input  logic [dstream_pkg::DATA_W-1:0]   rx_data,
   input  logic [dstream_pkg::BE_W-1:0]     rx_be,
   output logic                             mem_wr_ena,
   output logic [MEM_ADDR_WIDTH-1:0]        mem_wr_addr,
   output logic [dstream_pkg::DATA_W-1:0]   mem_wr_data,
   output logic [dstream_pkg::BE_W-1:0]     mem_wr_be
);

   logic                      active_q;   // wr_active one cycle ago
   logic                      first;      // first cycle of a write
   logic                      beat;
   logic [MEM_ADDR_WIDTH-1:0] base_addr;  // 64-bit word index from the header
   logic [MEM_ADDR_WIDTH-1:0] wr_addr;
   logic [MEM_ADDR_WIDTH-1:0] next_addr;

   assign first     = wr_active & ~active_q;
   assign beat      = rx_dv & wr_active;
   assign base_addr = rx_desc.h3.fmt[0] ? rx_desc.h4.addr[MEM_ADDR_WIDTH+2:3]
                                        : rx_desc.h3.addr[MEM_ADDR_WIDTH+2:3];
   assign next_addr = first ? base_addr : wr_addr;  // a beat may come with the ack

   always_ff @(posedge clk_in or negedge rstn) begin
      if (!rstn) begin
         active_q   <= 1'b0;
         mem_wr_ena <= 1'b0;
      end else begin
         active_q   <= wr_active;
         mem_wr_ena <= beat;   // one cycle behind rx_dv
      end
   end

   always_ff @(posedge clk_in) begin
      if (beat)
         wr_addr <= next_addr + 1'b1;
      else if (first)
         wr_addr <= base_addr;
      mem_wr_addr <= next_addr;
      mem_wr_data <= rx_data;
      mem_wr_be   <= rx_be;
   end

   a_wr_follows_dv : assert property (@(posedge clk_in) disable iff (!rstn)
      mem_wr_ena |-> $past(rx_dv))
      else $error("memory write without an rx beat");

endmodule

// ==== source/mem_rd_ctrl.sv ====
`timescale 1ns/1ps

module mem_rd_ctrl #(
   parameter int MEM_ADDR_WIDTH = 10
) (
   input  logic                           clk_in,
   input  logic                           rstn,
   cpl_job_if.rd                          job,
   beat_fifo_if.push                      fifo,
   output logic                           mem_rd_ena,
   output logic [MEM_ADDR_WIDTH-1:0]      mem_rd_addr,
   input  logic [dstream_pkg::DATA_W-1:0] mem_rd_data,
   input  logic                           mem_rd_data_valid
);

   logic [dstream_pkg::LEN_W-1:0] left;   // words still to request
   logic                          issue;

   assign issue = (left != '0) & ~fifo.almost_full;

   always_ff @(posedge clk_in or negedge rstn) begin
      if (!rstn) begin
         mem_rd_ena  <= 1'b0;
         mem_rd_addr <= '0;
         left        <= '0;
         fifo.wr     <= 1'b0;
      end else begin
         fifo.wr <= mem_rd_data_valid;
         if (job.start) begin
            mem_rd_ena  <= 1'b1;   // fifo is empty at start
            mem_rd_addr <= job.addr_dw[MEM_ADDR_WIDTH:1];
            left        <= job.num_beats - 1'b1;
         end else if (issue) begin
            mem_rd_ena  <= 1'b1;
            mem_rd_addr <= mem_rd_addr + 1'b1;
            left        <= left - 1'b1;
         end else begin
            mem_rd_ena  <= 1'b0;
         end
      end
   end

   // returned words, in order
   always_ff @(posedge clk_in) begin
      fifo.wdata <= mem_rd_data;
   end

   // reads in flight drain within the memory latency plus the push stage,
   // so the fifo cannot overflow
   a_no_push_full : assert property (@(posedge clk_in) disable iff (!rstn)
      fifo.almost_full [*5] |=> !fifo.wr)
      else $error("push while fifo full");

endmodule

// ==== source/cpl_fifo.sv ====
`timescale 1ns/1ps

module cpl_fifo #(
   parameter int FIFO_DEPTH = 16
) (
   input  logic       clk_in,
   input  logic       rstn,
   beat_fifo_if.store fifo
);

   localparam int PTR_W = $clog2(FIFO_DEPTH);

   logic [dstream_pkg::DATA_W-1:0] buf_mem [FIFO_DEPTH];
   logic [PTR_W-1:0]               wr_ptr;
   logic [PTR_W-1:0]               rd_ptr;
   logic [PTR_W:0]                 fill;

   assign fifo.empty       = fill == '0;
   // the beat being written counts as fill already
   assign fifo.almost_full = (int'(fill) + int'(fifo.wr)) >= FIFO_DEPTH - 4;

   always_ff @(posedge clk_in or negedge rstn) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill   <= '0;
      end else begin
         if (fifo.wr)
            wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (fifo.rd)
            rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         case ({fifo.wr, fifo.rd})
            2'b10:   fill <= fill + 1'b1;
            2'b01:   fill <= fill - 1'b1;
            default: fill <= fill;   // none, or one in and one out
         endcase
      end
   end

   always_ff @(posedge clk_in) begin
      if (fifo.wr) buf_mem[wr_ptr] <= fifo.wdata;
      if (fifo.rd) fifo.rdata <= buf_mem[rd_ptr];   // registered output
   end

   a_no_rd_empty : assert property (@(posedge clk_in) disable iff (!rstn)
      fifo.rd |-> !fifo.empty)
      else $error("fifo read while empty");

endmodule

// ==== source/cpl_tx_ctrl.sv ====
`timescale 1ns/1ps

module cpl_tx_ctrl (
   input  logic                           clk_in,
   input  logic                           rstn,
   input  logic [12:0]                    cfg_busdev,
   cpl_job_if.tx                          job,
   beat_fifo_if.pop                       fifo,
   input  logic                           tx_sel,
   input  logic                           tx_ack,
   input  logic                           tx_ws,
   output logic                           tx_ready,
   output logic                           tx_req,
   output logic [127:0]                   tx_desc,
   output logic [dstream_pkg::DATA_W-1:0] tx_data,
   output logic                           tx_dv,
   output logic                           tx_dfr
);

   localparam logic [1:0] TX_IDLE     = 2'd0;
   localparam logic [1:0] TX_SEND_REQ = 2'd1;   // tx_req up until tx_ack
   localparam logic [1:0] TX_PAYLD    = 2'd2;

   logic [1:0]                    state;
   logic [12:0]                   busdev_q;
   logic [dstream_pkg::LEN_W-1:0] pop_cnt;     // beats taken from the fifo
   logic                          grant;
   logic                          slot_free;   // output beat empty or leaving
   logic                          all_popped;

   assign grant      = tx_ready & tx_sel & ~fifo.empty;
   assign slot_free  = ~tx_dv | ~tx_ws;
   assign all_popped = pop_cnt == job.num_beats;
   assign fifo.rd    = (state != TX_IDLE) & ~fifo.empty & ~all_popped & slot_free;
   assign tx_data    = fifo.rdata;                // held while tx_ws stalls
   assign job.done   = tx_dv & ~tx_ws & ~tx_dfr;  // only the last beat has dfr low

   // cpld header, everything not listed is zero
   assign tx_desc = {1'b0, dstream_pkg::CPLD_FMT_TYPE, 14'h0, job.length,
                     busdev_q, 3'h0,              // completer id, function 0
                     4'h0,                        // successful, bcm clear
                     {job.length, 2'b00},         // byte count
                     job.req_id, job.tag, 1'b0, job.lower_addr, 32'h0};

   always_ff @(posedge clk_in or negedge rstn) begin
      if (!rstn) begin
         state    <= TX_IDLE;
         busdev_q <= '0;
         pop_cnt  <= '0;
         tx_ready <= 1'b0;
         tx_req   <= 1'b0;
         tx_dv    <= 1'b0;
         tx_dfr   <= 1'b0;
      end else begin
         busdev_q <= cfg_busdev;
         if (job.start)
            tx_ready <= 1'b1;   // ask the arbiter
         else if (state == TX_IDLE && grant)
            tx_ready <= 1'b0;
         if (job.start)
            pop_cnt <= '0;
         else if (fifo.rd)
            pop_cnt <= pop_cnt + 1'b1;
         tx_dv <= fifo.rd | (tx_dv & tx_ws);
         if (fifo.rd && pop_cnt == job.num_beats - 1'b1)
            tx_dfr <= 1'b0;     // low while the last beat is out
         case (state)
            TX_IDLE: begin
               if (grant) begin
                  state  <= TX_SEND_REQ;
                  tx_req <= 1'b1;
                  tx_dfr <= 1'b1;
               end
            end
            TX_SEND_REQ: begin
               if (tx_ack) begin
                  tx_req <= 1'b0;
                  state  <= TX_PAYLD;
               end
            end
            default: if (all_popped && slot_free) state <= TX_IDLE;
         endcase
      end
   end

   a_req_hold : assert property (@(posedge clk_in) disable iff (!rstn)
      tx_req && !tx_ack |=> tx_req)
      else $error("tx_req dropped before tx_ack");

endmodule

// ==== source/dstream_target_top.sv ====
`timescale 1ns/1ps

module dstream_target_top #(
   parameter int MEM_ADDR_WIDTH = 10,
   parameter int FIFO_DEPTH     = 16
) (
   input  logic                           clk_in,
   input  logic                           rstn,
   input  logic [12:0]                    cfg_busdev,
   // rx request side
   input  logic                           rx_req,
   input  logic [135:0]                   rx_desc,
   input  logic [dstream_pkg::DATA_W-1:0] rx_data,
   input  logic [dstream_pkg::BE_W-1:0]   rx_be,
   input  logic                           rx_dv,
   input  logic                           rx_dfr,
   output logic                           rx_ack,
   // endpoint memory
   output logic                           mem_wr_ena,
   output logic [MEM_ADDR_WIDTH-1:0]      mem_wr_addr,
   output logic [dstream_pkg::DATA_W-1:0] mem_wr_data,
   output logic [dstream_pkg::BE_W-1:0]   mem_wr_be,
   output logic                           mem_rd_ena,
   output logic [MEM_ADDR_WIDTH-1:0]      mem_rd_addr,
   input  logic [dstream_pkg::DATA_W-1:0] mem_rd_data,
   input  logic                           mem_rd_data_valid,
   // tx completion side
   input  logic                           tx_sel,
   input  logic                           tx_ack,
   input  logic                           tx_ws,
   output logic                           tx_ready,
   output logic                           tx_req,
   output logic [127:0]                   tx_desc,
   output logic [dstream_pkg::DATA_W-1:0] tx_data,
   output logic                           tx_dv,
   output logic                           tx_dfr
);

   logic wr_active;

   cpl_job_if   job_if ();
   beat_fifo_if fifo_if ();

   rx_req_ctrl i_rx_req_ctrl (
      .clk_in, .rstn, .rx_req, .rx_desc, .rx_dfr, .rx_ack, .wr_active, .job(job_if.src));

   mem_wr_path #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) i_mem_wr_path (
      .clk_in, .rstn, .rx_desc, .wr_active, .rx_dv, .rx_data, .rx_be,
      .mem_wr_ena, .mem_wr_addr, .mem_wr_data, .mem_wr_be);

   mem_rd_ctrl #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) i_mem_rd_ctrl (
      .clk_in, .rstn, .job(job_if.rd), .fifo(fifo_if.push),
      .mem_rd_ena, .mem_rd_addr, .mem_rd_data, .mem_rd_data_valid);

   cpl_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_cpl_fifo (
      .clk_in, .rstn, .fifo(fifo_if.store));

   cpl_tx_ctrl i_cpl_tx_ctrl (
      .clk_in, .rstn, .cfg_busdev, .job(job_if.tx), .fifo(fifo_if.pop),
      .tx_sel, .tx_ack, .tx_ws, .tx_ready, .tx_req, .tx_desc, .tx_data, .tx_dv, .tx_dfr);

endmodule

// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
   output logic clk_in,
   output logic rstn
);

   initial begin
      clk_in = 1'b0;
      forever #5 clk_in = ~clk_in;   // 10 ns period
   end

   initial begin
      rstn = 1'b0;
      repeat (4) @(posedge clk_in);   // reset held for 4 cycles
      @(negedge clk_in) rstn = 1'b1;
   end

endmodule

// ==== dv/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;

   localparam int N_REQ = 12;

   logic clk_in, rstn;
   logic [12:0]  cfg_busdev = 13'h0a5;
   logic         rx_req, rx_dv, rx_dfr, tx_sel, tx_ack, tx_ws, mem_rd_data_valid;
   logic [135:0] rx_desc;
   logic [63:0]  rx_data, mem_rd_data, tx_data, mem_wr_data, exp_rd_data;
   logic [7:0]   rx_be, mem_wr_be;
   logic         rx_ack, mem_wr_ena, mem_rd_ena, tx_ready, tx_req, tx_dv, tx_dfr;
   logic [9:0]   mem_wr_addr, mem_rd_addr;
   logic [127:0] tx_desc, exp_desc;
   logic [63:0]  mem_model [1024];   // endpoint memory
   logic         p1_v, p2_v;          // read return pipe
   logic [9:0]   p1_a, p2_a, exp_wr_addr, wr_exp_addr_q, rd_base;
   logic [63:0]  wr_exp_data_q;
   logic [7:0]   wr_exp_be_q;
   int           rd_idx, rd_beats;
   int           seed = 32'h6a15_6784;
   logic [31:0]  pat;

   tb_clk_gen i_clk_gen (.clk_in, .rstn);

   // small fifo so that long reads fill it and stall the memory reads
   dstream_target_top #(.MEM_ADDR_WIDTH(10), .FIFO_DEPTH(8)) i_dut (.*);

   task automatic stop_on_error;
      $display("=== FAIL ===");
      $fatal(1, "stopped at first error");
   endtask

   // words needed: dw offset in the first word plus length, rounded up
   function automatic int beats_for(input logic [31:0] addr, input logic [9:0] len);
      return (int'(addr[2]) + int'(len) + 1) / 2;
   endfunction

   function automatic logic [135:0] make_desc(input logic wr, input logic fmt4,
         input logic [9:0] len, input logic [15:0] rid, input logic [7:0] tag,
         input logic [31:0] addr, input logic [31:0] hi);
      return {8'h01, 1'b0, wr, fmt4, 5'h00, 14'h0, len, rid, tag, 8'hff,
              fmt4 ? {hi, addr} : {addr, 32'h0}};
   endfunction

   ////////////////////////////////////////
   // memory model
   ////////////////////////////////////////

   assign exp_rd_data = mem_model[10'(rd_base + rd_idx)];

   always @(posedge clk_in) begin
      p1_v <= mem_rd_ena;   // two cycle read answer
      p1_a <= mem_rd_addr;
      p2_v <= p1_v;
      p2_a <= p1_a;
      if (mem_wr_ena)
         for (int b = 0; b < 8; b++)
            if (mem_wr_be[b]) mem_model[mem_wr_addr][8*b +: 8] <= mem_wr_data[8*b +: 8];
      wr_exp_addr_q <= exp_wr_addr;   // what the beat on rx_dv should produce
      wr_exp_data_q <= rx_data;
      wr_exp_be_q   <= rx_be;
      if (tx_dv && !tx_ws) rd_idx <= rd_idx + 1;   // accepted cpl beat
   end

   always @(negedge clk_in) begin
      mem_rd_data_valid <= p2_v;
      mem_rd_data       <= mem_model[p2_a];
      tx_ws             <= ($random(seed) % 3) == 0;   // random wait states
   end

   ////////////////////////////////////////
   // checks
   ////////////////////////////////////////

   a_rst_low : assert property (@(posedge clk_in) $rose(rstn) |-> !(rx_ack | mem_wr_ena |
         mem_rd_ena | tx_ready | tx_req | tx_dv | tx_dfr))
      else begin
         $display("control output high right after reset");
         stop_on_error();
      end
   a_ack_follow : assert property (@(posedge clk_in) disable iff (!rstn)
         $rose(rx_req) |=> rx_ack ##1 !rx_ack)
      else begin
         $display("rx_ack missing or longer than one cycle");
         stop_on_error();
      end
   a_wr_ena : assert property (@(posedge clk_in) disable iff (!rstn) rx_dv |=> mem_wr_ena)
      else begin
         $display("ERR mem_wr_ena got %h exp 1", $sampled(mem_wr_ena));
         stop_on_error();
      end
   a_wr_addr : assert property (@(posedge clk_in) disable iff (!rstn)
         mem_wr_ena |-> mem_wr_addr == wr_exp_addr_q)
      else begin
         $display("ERR mem_wr_addr got %h exp %h", $sampled(mem_wr_addr), $sampled(wr_exp_addr_q));
         stop_on_error();
      end
   a_wr_data : assert property (@(posedge clk_in) disable iff (!rstn)
         mem_wr_ena |-> mem_wr_data == wr_exp_data_q && mem_wr_be == wr_exp_be_q)
      else begin
         $display("ERR mem_wr_data/be got %h/%h exp %h/%h", $sampled(mem_wr_data),
                  $sampled(mem_wr_be), $sampled(wr_exp_data_q), $sampled(wr_exp_be_q));
         stop_on_error();
      end
   a_desc : assert property (@(posedge clk_in) disable iff (!rstn) tx_req |-> tx_desc == exp_desc)
      else begin
         $display("ERR tx_desc got %h exp %h", $sampled(tx_desc), $sampled(exp_desc));
         stop_on_error();
      end
   a_rd_data : assert property (@(posedge clk_in) disable iff (!rstn)
         tx_dv && !tx_ws |-> tx_data == exp_rd_data)
      else begin
         $display("ERR tx_data got %h exp %h", $sampled(tx_data), $sampled(exp_rd_data));
         stop_on_error();
      end
   a_dfr : assert property (@(posedge clk_in) disable iff (!rstn)
         tx_dv && !tx_ws |-> tx_dfr == (rd_idx != rd_beats - 1))
      else begin
         $display("ERR tx_dfr got %h exp %h", $sampled(tx_dfr), $sampled(rd_idx != rd_beats - 1));
         stop_on_error();
      end
   a_no_extra_beat : assert property (@(posedge clk_in) disable iff (!rstn)
         tx_dv && !tx_ws && !tx_dfr |=> !tx_dv)   // nothing follows the last beat
      else begin
         $display("ERR tx_dv got %h exp 0", $sampled(tx_dv));
         stop_on_error();
      end
   a_req_hold : assert property (@(posedge clk_in) disable iff (!rstn)
         tx_req && !tx_ack |=> tx_req)
      else begin
         $display("tx_req dropped before tx_ack");
         stop_on_error();
      end

   ////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////

   task automatic send_write(input logic fmt4, input logic [9:0] len,
         input logic [31:0] addr, input logic [31:0] hi);
      int nb;
      nb = beats_for(addr, len);
      @(negedge clk_in);
      rx_desc = make_desc(1'b1, fmt4, len, 16'($random(seed)), 8'($random(seed)), addr, hi);
      rx_req  = 1'b1;
      rx_dfr  = 1'b1;
      do @(negedge clk_in); while (!rx_ack);
      rx_req = 1'b0;
      for (int k = 0; k < nb; k++) begin
         if (k != 0) @(negedge clk_in);
         rx_dv       = 1'b1;
         rx_data     = {$random(seed), $random(seed)};
         rx_be       = 8'($random(seed));
         exp_wr_addr = addr[12:3] + 10'(k);   // start word plus beat index
         rx_dfr      = (k != nb - 1);
      end
      @(negedge clk_in);
      rx_dv  = 1'b0;
      rx_dfr = 1'b0;
   endtask

   task automatic send_read(input logic fmt4, input logic [9:0] len,
         input logic [31:0] addr, input logic [31:0] hi);
      logic [15:0] rid;
      logic [7:0]  tag;
      int          dly_sel, dly_ack;
      rid      = 16'($random(seed));
      tag      = 8'($random(seed));
      dly_sel  = $random(seed) & 7;   // late tx_sel
      dly_ack  = $random(seed) & 3;
      rd_base  = addr[12:3];
      rd_beats = beats_for(addr, len);
      rd_idx   = 0;
      // cpld: fmt/type, length, completer id, status 0, byte count, rid, tag, lower addr
      exp_desc = {1'b0, 7'h4a, 14'h0, len, cfg_busdev, 3'h0, 4'h0, {len, 2'b00},
                  rid, tag, 1'b0, addr[6:0], 32'h0};
      @(negedge clk_in);
      rx_desc = make_desc(1'b0, fmt4, len, rid, tag, addr, hi);
      rx_req  = 1'b1;
      do @(negedge clk_in); while (!rx_ack);
      rx_req = 1'b0;
      fork
         begin
            do @(negedge clk_in); while (!tx_ready);
            repeat (dly_sel) @(negedge clk_in);
            tx_sel = 1'b1;
            do @(negedge clk_in); while (!tx_req);
            tx_sel = 1'b0;
         end
         begin
            do @(negedge clk_in); while (!tx_req);
            repeat (dly_ack) @(negedge clk_in);
            tx_ack = 1'b1;
            @(negedge clk_in) tx_ack = 1'b0;
         end
         begin
            do @(negedge clk_in); while (rd_idx != rd_beats);
         end
      join
   endtask

   initial begin
      rx_req            = 0;
      rx_dv             = 0;
      rx_dfr            = 0;
      rx_desc           = '0;
      rx_data           = '0;
      rx_be             = '0;
      tx_sel            = 0;
      tx_ack            = 0;
      tx_ws             = 0;
      exp_wr_addr       = '0;
      exp_desc          = '0;
      mem_rd_data       = '0;
      mem_rd_data_valid = 0;
      rd_base           = '0;
      rd_idx            = 0;
      rd_beats          = 0;
      pat = $random(seed);
      for (int i = 0; i < 1024; i++)
         mem_model[i] = {pat ^ 32'(i), ~pat ^ 32'(i)};   // every word distinct
      @(posedge rstn);
      for (int i = 0; i < N_REQ; i++) begin
         // i[0] picks write, i[1] picks the 4dw header
         if (i[0])
            send_write(i[1], 10'(($random(seed) & 15) + 1),
                       {19'h0, 10'($random(seed)), 1'($random(seed)), 2'b00}, $random(seed));
         else
            send_read(i[1], 10'(($random(seed) & 15) + 1),
                      {19'h0, 10'($random(seed)), 1'($random(seed)), 2'b00}, $random(seed));
      end
      repeat (10) @(negedge clk_in);
      $display("=== PASS ===");
      $finish;
   end

   // watchdog, 400 cycles per request
   initial begin
      #(N_REQ * 400 * 10);
      $display("run did not complete before the watchdog expired");
      stop_on_error();
   end

endmodule

// ==== dstream_target.f ====
source/dstream_pkg.sv
source/cpl_job_if.sv
source/beat_fifo_if.sv
source/rx_req_ctrl.sv
source/mem_wr_path.sv
source/mem_rd_ctrl.sv
source/cpl_fifo.sv
source/cpl_tx_ctrl.sv
source/dstream_target_top.sv
dv/tb_clk_gen.sv
dv/tb_top.sv

// ==== Bender.yml ====
package:
  name: dstream_target

sources:
  - files:
      - source/dstream_pkg.sv
      - source/cpl_job_if.sv
      - source/beat_fifo_if.sv
      - source/rx_req_ctrl.sv
      - source/mem_wr_path.sv
      - source/mem_rd_ctrl.sv
      - source/cpl_fifo.sv
      - source/cpl_tx_ctrl.sv
      - source/dstream_target_top.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_top.sv
